// ==== dv/upsz_chk.sv ====
//////////////////////////////
// Handshake assertions bound
// onto the upsizer top level
//////////////////////////////
`timescale 1ns/100ps
module upsz_chk (
	input logic                 i_clk,
	input logic                 i_rst,
	input logic                 i_cyc,
	input logic                 i_stall,
	input bus_pkg::narrow_rsp_t i_rsp
);

	// Failed assertions, read back by the testbench at the end
	int fail_cnt = 0;

	// Ack and err are exclusive
	ack_err_excl: assert property (@(posedge i_clk) disable iff (i_rst)
		!(i_rsp.ack && i_rsp.err))
	else
	begin
		$error("ack and err are high in the same cycle");
		fail_cnt++;
	end

	// A response needs the cycle held through the whole minimum latency
	rsp_needs_cyc: assert property (@(posedge i_clk) disable iff (i_rst)
		(i_rsp.ack || i_rsp.err) |->
		($past(i_cyc, 1) && $past(i_cyc, 2) && $past(i_cyc, 3) && $past(i_cyc, 4)))
	else
	begin
		$error("response seen without cyc held since its request");
		fail_cnt++;
	end

	// First cycle out of reset is quiet
	quiet_after_rst: assert property (@(posedge i_clk)
		$fell(i_rst) |-> (!i_rsp.ack && !i_rsp.err && !i_stall))
	else
	begin
		$error("outputs active in the cycle after reset");
		fail_cnt++;
	end

endmodule

// ==== dv/upsz_tb.sv ====
//////////////////////////////
// Testbench for the upsizer
// Clock, reset, LCG stimulus
// Shadow model, scoreboard
// Watchdog and verdict
//////////////////////////////
`timescale 1ns/100ps
module upsz_tb;

	// Clock and drive timing, in ns
	localparam int CLK_PERIOD = 20;
	localparam int DRIVE_DLY = 2;
	localparam int RST_CYCLES = 10;
	// Narrow words behind the implemented rows
	localparam int N_WORDS = mem_pkg::MEM_ROWS * bus_pkg::LANES;
	localparam int N_STREAM = 300;
	// Stream plus all directed requests, rounded up
	localparam int N_REQ_TOTAL = N_STREAM + 40;
	// Per request: stall wait plus four cycles of latency
	localparam int WORST_LAT = 8;
	localparam int TIMEOUT_NS = (N_REQ_TOTAL * WORST_LAT + 300) * CLK_PERIOD;
	localparam int STALL_LIMIT = 20;
	localparam int DRAIN_LIMIT = 50;
	// Out-of-range row, aliases row 44 in the low address bits
	localparam int OOR_ROW = 300;
	localparam int OOR_WORD = OOR_ROW * bus_pkg::LANES + 1;
	localparam int ALIAS_WORD = (OOR_ROW - mem_pkg::MEM_ROWS) * bus_pkg::LANES + 1;

	// Expected response and which data bits are known
	typedef struct packed {
		bus_pkg::narrow_rsp_t  rsp;
		bus_pkg::narrow_data_t mask;
	} expect_t;

	logic i_clk;
	logic i_rst;
	logic i_cyc;
	logic i_stb;
	bus_pkg::narrow_req_t i_req;
	logic o_stall;
	bus_pkg::narrow_rsp_t o_rsp;

	// Scoreboard and reference state
	expect_t exp_q [$];
	expect_t mon_exp;
	bus_pkg::narrow_data_t shadow [N_WORDS];
	bus_pkg::narrow_data_t known [N_WORDS];
	logic [31:0] rng_state;
	int mismatch_cnt;
	int other_cnt;
	int stall_cnt;
	int assert_fails;
	bus_pkg::narrow_data_t rnd;

	upsz_top DUT (
		.i_clk   (i_clk),
		.i_rst   (i_rst),
		.i_cyc   (i_cyc),
		.i_stb   (i_stb),
		.i_req   (i_req),
		.o_stall (o_stall),
		.o_rsp   (o_rsp)
	);

	bind upsz_top upsz_chk u_chk (
		.i_clk   (i_clk),
		.i_rst   (i_rst),
		.i_cyc   (i_cyc),
		.i_stall (o_stall),
		.i_rsp   (o_rsp)
	);

	initial
	begin
		i_clk = 1'b0;
		forever #(CLK_PERIOD / 2) i_clk = ~i_clk;
	end

	//////////////////////////////
	// Reference model
	//////////////////////////////

	function automatic logic [31:0] next_rand();
		rng_state = rng_state * 32'd1664525 + 32'd1013904223;
		return rng_state;
	endfunction

	function automatic bus_pkg::narrow_req_t make_req(input logic we, input int word,
		input bus_pkg::narrow_data_t data, input bus_pkg::narrow_sel_t sel);
		bus_pkg::narrow_req_t r;
		r.we = we;
		r.addr.word = bus_pkg::NADDR_W'(word);
		r.data = data;
		r.sel = sel;
		return r;
	endfunction

	// Applies one request to the shadow words, returns what the DUT owes
	function automatic expect_t model_access(input bus_pkg::narrow_req_t req);
		expect_t e;
		int w;
		e = '0;
		w = int'(req.addr.word);
		// Past the last implemented row
		if (w >= N_WORDS)
		begin
			e.rsp.err = 1'b1;
			return e;
		end
		e.rsp.ack = 1'b1;
		if (req.we)
		begin
			// Byte-wise merge, write data itself is not checked
			for (int b = 0; b < bus_pkg::NSEL_W; b++)
				if (req.sel[b])
				begin
					shadow[w][8*b +: 8] = req.data[8*b +: 8];
					known[w][8*b +: 8] = 8'hff;
				end
		end
		else
		begin
			e.rsp.data = shadow[w];
			e.mask = known[w];
		end
		return e;
	endfunction

	//////////////////////////////
	// Compare tasks
	//////////////////////////////

	task automatic check_rsp(input bus_pkg::narrow_rsp_t got, input expect_t exp);
		if (got.ack !== exp.rsp.ack || got.err !== exp.rsp.err)
		begin
			$display("Mismatch at %0t: o_rsp.ack/err got %b/%b expected %b/%b",
				$time, got.ack, got.err, exp.rsp.ack, exp.rsp.err);
			mismatch_cnt++;
		end
		else if (((got.data ^ exp.rsp.data) & exp.mask) !== '0)
		begin
			$display("Mismatch at %0t: o_rsp.data got %h expected %h (known bits %h)",
				$time, got.data, exp.rsp.data, exp.mask);
			mismatch_cnt++;
		end
	endtask

	task automatic check_err(input bus_pkg::narrow_rsp_t got);
		if (got.err !== 1'b1 || got.ack !== 1'b0)
		begin
			$display("Mismatch at %0t: o_rsp.ack/err got %b/%b expected 0/1",
				$time, got.ack, got.err);
			mismatch_cnt++;
		end
	endtask

	task automatic check_idle(input logic stall, input bus_pkg::narrow_rsp_t got);
		if (stall !== 1'b0)
		begin
			$display("Mismatch at %0t: o_stall got %b expected 0", $time, stall);
			mismatch_cnt++;
		end
		if (got.ack !== 1'b0 || got.err !== 1'b0)
		begin
			$display("Mismatch at %0t: o_rsp.ack/err got %b/%b expected 0/0",
				$time, got.ack, got.err);
			mismatch_cnt++;
		end
	endtask

	// Compare process, outputs are settled at the falling edge
	always @(negedge i_clk)
	begin
		if (!i_rst && (o_rsp.ack === 1'b1 || o_rsp.err === 1'b1))
		begin
			if (exp_q.size() == 0)
			begin
				$display("Error at %0t: response with no request outstanding", $time);
				other_cnt++;
			end
			else
			begin
				mon_exp = exp_q.pop_front();
				if (mon_exp.rsp.err)
					check_err(o_rsp);
				else
					check_rsp(o_rsp, mon_exp);
			end
		end
	end

	//////////////////////////////
	// Bus driver
	//////////////////////////////

	// Entered and left just after a rising edge
	task automatic drive_req(input bus_pkg::narrow_req_t req);
		int waited;
		waited = 0;
		i_cyc = 1'b1;
		i_stb = 1'b1;
		i_req = req;
		@(negedge i_clk);
		while (o_stall)
		begin
			waited++;
			stall_cnt++;
			if (waited > STALL_LIMIT)
			begin
				$display("Error at %0t: o_stall held for %0d cycles", $time, waited);
				other_cnt++;
				break;
			end
			@(negedge i_clk);
		end
		// Taken at this edge
		@(posedge i_clk);
		exp_q.push_back(model_access(req));
		#DRIVE_DLY;
	endtask

	task automatic stop_strobe();
		i_stb = 1'b0;
	endtask

	task automatic wait_drain();
		int cycles;
		cycles = 0;
		while (exp_q.size() != 0 && cycles < DRAIN_LIMIT)
		begin
			@(posedge i_clk);
			cycles++;
		end
		if (exp_q.size() != 0)
		begin
			$display("Error at %0t: %0d responses never arrived", $time, exp_q.size());
			other_cnt++;
			exp_q.delete();
		end
		@(posedge i_clk);
		#DRIVE_DLY;
	endtask

	// Abort after an error, cycle low for two clocks
	task automatic drop_cycle();
		i_cyc = 1'b0;
		i_stb = 1'b0;
		repeat (2) @(posedge i_clk);
		#DRIVE_DLY;
	endtask

	//////////////////////////////
	// Watchdog
	//////////////////////////////

	initial
	begin
		#(TIMEOUT_NS);
		$display("Error at %0t: watchdog expired after %0d ns", $time, TIMEOUT_NS);
		$display("TB FAILED");
		$finish;
	end

	//////////////////////////////
	// Test sequence
	//////////////////////////////

	initial
	begin
		i_rst = 1'b1;
		i_cyc = 1'b0;
		i_stb = 1'b0;
		i_req = '0;
		rng_state = 32'he989_763a;
		mismatch_cnt = 0;
		other_cnt = 0;
		stall_cnt = 0;
		for (int w = 0; w < N_WORDS; w++)
		begin
			shadow[w] = '0;
			known[w] = '0;
		end
		repeat (RST_CYCLES) @(posedge i_clk);
		#DRIVE_DLY;
		i_rst = 1'b0;

		// Idle bus after reset
		repeat (5)
		begin
			@(negedge i_clk);
			check_idle(o_stall, o_rsp);
		end
		@(posedge i_clk);
		#DRIVE_DLY;

		// Four lanes of row 3, distinct values
		for (int l = 0; l < bus_pkg::LANES; l++)
			drive_req(make_req(1'b1, 12 + l, 32'h3c5a_0a00 + 32'(l * 17), 4'hf));
		for (int l = 0; l < bus_pkg::LANES; l++)
			drive_req(make_req(1'b0, 12 + l, '0, 4'hf));
		stop_strobe();
		wait_drain();

		// Partial writes merging into word 21
		drive_req(make_req(1'b1, 21, 32'h1122_3344, 4'b1111));
		drive_req(make_req(1'b1, 21, 32'haabb_ccdd, 4'b0101));
		drive_req(make_req(1'b1, 21, 32'h5566_7788, 4'b1000));
		drive_req(make_req(1'b1, 21, 32'h99ee_f012, 4'b0010));
		drive_req(make_req(1'b1, 21, 32'hffff_ffff, 4'b0000));
		drive_req(make_req(1'b0, 21, '0, 4'hf));
		stop_strobe();
		wait_drain();

		// Random back-to-back stream over the low 128 words
		stall_cnt = 0;
		for (int n = 0; n < N_STREAM; n++)
		begin
			rnd = next_rand();
			// Top bit picks read or write, the LCG low bit only alternates
			if (rnd[31])
				drive_req(make_req(1'b1, int'(rnd[15:9]), next_rand(), rnd[7:4]));
			else
				drive_req(make_req(1'b0, int'(rnd[15:9]), '0, 4'hf));
		end
		stop_strobe();
		wait_drain();
		if (stall_cnt == 0)
		begin
			$display("Error at %0t: no stall seen during the back-to-back stream", $time);
			other_cnt++;
		end

		// Out-of-range write, then read, each followed by an abort
		drive_req(make_req(1'b1, ALIAS_WORD, 32'h1357_9bdf, 4'hf));
		stop_strobe();
		wait_drain();
		drive_req(make_req(1'b1, OOR_WORD, 32'hffff_ffff, 4'hf));
		stop_strobe();
		wait_drain();
		drop_cycle();
		drive_req(make_req(1'b0, 4095, '0, 4'hf));
		stop_strobe();
		wait_drain();
		drop_cycle();

		// Earlier words survive the aborts
		drive_req(make_req(1'b0, ALIAS_WORD, '0, 4'hf));
		for (int w = 12; w < 16; w++)
			drive_req(make_req(1'b0, w, '0, 4'hf));
		drive_req(make_req(1'b0, 21, '0, 4'hf));
		for (int w = 0; w < 8; w++)
			drive_req(make_req(1'b0, w * 9, '0, 4'hf));
		stop_strobe();
		wait_drain();
		i_cyc = 1'b0;
		repeat (3) @(posedge i_clk);

		assert_fails = DUT.u_chk.fail_cnt;
		$display("Summary: %0d mismatches, %0d other errors, %0d assertion failures",
			mismatch_cnt, other_cnt, assert_fails);
		if (mismatch_cnt == 0 && other_cnt == 0 && assert_fails == 0)
			$display("TB PASSED");
		else
			$display("TB FAILED");
		$finish;
	end

endmodule

// ==== run.sh ====
#!/bin/sh
# Build and run the upsizer testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
	--top-module upsz_tb -f sim.f \
	--Mdir obj_dir -o upsz_sim
status=$?
if [ $status -ne 0 ]; then
	echo "Verilator build failed with status $status"
	exit 1
fi

out=$(./obj_dir/upsz_sim +verilator+error+limit+100)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if printf '%s\n' "$out" | grep -qx "TB PASSED"; then
	exit 0
fi
exit 1

// ==== sim.f ====
src/bus_pkg.sv
src/mem_pkg.sv
src/upsz_req_stage.sv
src/lane_tag_fifo.sv
src/upsz_rsp_stage.sv
src/wide_ram.sv
src/upsz_top.sv
dv/upsz_chk.sv
dv/upsz_tb.sv

// ==== src/bus_pkg.sv ====
//////////////////////////////
// Narrow and wide bus widths
// Narrow word address union
// Request and response structs
//////////////////////////////
package bus_pkg;

	//////////////////////////////
	// Widths
	//////////////////////////////

	// Narrow side data word
	localparam int NARROW_DW = 32;
	// Narrow words per wide row
	localparam int LANES = 4;
	localparam int LANE_W = $clog2(LANES);
	// Wide side data word, four lanes
	localparam int WIDE_DW = NARROW_DW * LANES;
	// Byte select widths
	localparam int NSEL_W = NARROW_DW / 8;
	localparam int WSEL_W = WIDE_DW / 8;
	// Wide row address
	localparam int ROW_W = 10;
	// Narrow word address, row plus lane
	localparam int NADDR_W = ROW_W + LANE_W;

	//////////////////////////////
	// Basic types
	//////////////////////////////

	typedef logic [LANE_W-1:0] lane_t;
	typedef logic [ROW_W-1:0] row_t;
	typedef logic [NARROW_DW-1:0] narrow_data_t;
	typedef logic [NSEL_W-1:0] narrow_sel_t;
	typedef logic [WIDE_DW-1:0] wide_data_t;
	typedef logic [WSEL_W-1:0] wide_sel_t;

	// Row in the upper bits, lane in the lowest bits
	typedef struct packed {
		row_t  row;
		lane_t lane;
	} narrow_addr_split_t;

	// Same word seen flat or as row and lane
	typedef union packed {
		logic [NADDR_W-1:0] word;
		narrow_addr_split_t split;
	} narrow_addr_t;

	//////////////////////////////
	// Bus payloads
	//////////////////////////////

	// Narrow master request
	typedef struct packed {
		logic         we;
		narrow_addr_t addr;
		narrow_data_t data;
		narrow_sel_t  sel;
	} narrow_req_t;

	// Narrow response, ack and err are one cycle pulses
	typedef struct packed {
		logic         ack;
		logic         err;
		narrow_data_t data;
	} narrow_rsp_t;

	// Wide request, one lane populated
	typedef struct packed {
		logic       we;
		row_t       row;
		wide_data_t data;
		wide_sel_t  sel;
	} wide_req_t;

	// Wide response carrying the full row
	typedef struct packed {
		logic       ack;
		logic       err;
		wide_data_t data;
	} wide_rsp_t;

endpackage

// ==== src/lane_tag_fifo.sv ====
//////////////////////////////
// In-order lane number queue
//////////////////////////////
`timescale 1ns/100ps
module lane_tag_fifo (
	input  logic           i_clk,
	input  logic           i_rst,
	input  logic           i_flush,
	input  logic           i_push,
	input  bus_pkg::lane_t i_tag,
	input  logic           i_pop,
	output bus_pkg::lane_t o_tag,
	output logic           o_full
);

	// Tag storage
	bus_pkg::lane_t tags [mem_pkg::TAG_DEPTH];
	// Pointers and occupancy
	logic [mem_pkg::TAG_PTR_W-1:0] wr_ptr;
	logic [mem_pkg::TAG_PTR_W-1:0] rd_ptr;
	logic [mem_pkg::TAG_CNT_W-1:0] count;
	// Qualified operations
	logic do_push;
	logic do_pop;

	assign o_full = (count == mem_pkg::TAG_CNT_W'(mem_pkg::TAG_DEPTH));
	// Head of queue, read without a pop
	assign o_tag = tags[rd_ptr];

	assign do_push = i_push && !o_full;
	assign do_pop = i_pop && (count != '0);

	// Wrap at the last entry
	function automatic logic [mem_pkg::TAG_PTR_W-1:0] next_ptr(
		input logic [mem_pkg::TAG_PTR_W-1:0] ptr
	);
		if (ptr == mem_pkg::TAG_PTR_W'(mem_pkg::TAG_DEPTH - 1))
			return '0;
		return ptr + 1'b1;
	endfunction

	always_ff @(posedge i_clk)
	begin
		// Dropped cycle empties the queue too
		if (i_rst || i_flush)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end
		else
		begin
			if (do_push)
				wr_ptr <= next_ptr(wr_ptr);
			if (do_pop)
				rd_ptr <= next_ptr(rd_ptr);
			// Push and pop together keep the count
			if (do_push && !do_pop)
				count <= count + 1'b1;
			else if (do_pop && !do_push)
				count <= count - 1'b1;
		end
	end

	always_ff @(posedge i_clk)
	begin
		if (do_push)
			tags[wr_ptr] <= i_tag;
	end

endmodule

// ==== src/mem_pkg.sv ====
//////////////////////////////
// Wide memory geometry
// Read latency, tag queue depth
//////////////////////////////
package mem_pkg;

	//////////////////////////////
	// Memory
	//////////////////////////////

	// Implemented rows, anything above answers err
	localparam int MEM_ROWS = 256;
	// Index width into the storage array
	localparam int MEM_AW = $clog2(MEM_ROWS);
	// Acceptance to response, in cycles
	localparam int RD_LAT = 2;

	//////////////////////////////
	// Lane-tag queue
	//////////////////////////////

	// Outstanding wide requests
	localparam int TAG_DEPTH = 2;
	// Pointer width
	localparam int TAG_PTR_W = (TAG_DEPTH > 1) ? $clog2(TAG_DEPTH) : 1;
	// Count goes up to TAG_DEPTH inclusive
	localparam int TAG_CNT_W = $clog2(TAG_DEPTH + 1);

endpackage

// ==== src/upsz_req_stage.sv ====
//////////////////////////////
// Narrow to wide request stage
// Lane placement, stall, tag push
//////////////////////////////
`timescale 1ns/100ps
module upsz_req_stage (
	input  logic                 i_clk,
	input  logic                 i_rst,
	input  logic                 i_cyc,
	input  logic                 i_stb,
	input  bus_pkg::narrow_req_t i_req,
	input  logic                 i_tag_full,
	input  logic                 i_wide_err,
	output logic                 o_stall,
	output logic                 o_wide_cyc,
	output logic                 o_wide_stb,
	output bus_pkg::wide_req_t   o_wide_req,
	output logic                 o_tag_push,
	output bus_pkg::lane_t       o_tag
);

	// Control state
	logic r_cyc;
	logic r_stb;
	// Set by a wide error, held until cyc drops
	logic r_abort;
	// Held wide request and its lane
	bus_pkg::wide_req_t r_req;
	bus_pkg::lane_t r_lane;
	// Narrow request taken this edge
	logic accept;
	// Narrow word moved into its lane
	bus_pkg::wide_data_t lane_data;
	bus_pkg::wide_sel_t lane_sel;

	//////////////////////////////
	// Handshake
	//////////////////////////////

	// Only the full tag queue can hold a loaded request
	assign o_stall = r_stb && i_tag_full;
	// No new work while aborting after an error
	assign accept = i_cyc && i_stb && !o_stall && !r_abort;

	// Narrow cyc gates the wide cycle at once
	assign o_wide_cyc = r_cyc && i_cyc;
	assign o_wide_stb = r_stb && !i_tag_full;
	// Wide slave never stalls, so strobe with cyc is acceptance
	assign o_tag_push = o_wide_cyc && o_wide_stb;
	assign o_tag = r_lane;
	assign o_wide_req = r_req;

	// Little-endian lanes, other lanes' selects stay zero
	always_comb
	begin
		lane_data = bus_pkg::wide_data_t'(i_req.data)
			<< (bus_pkg::NARROW_DW * i_req.addr.split.lane);
		lane_sel = bus_pkg::wide_sel_t'(i_req.sel)
			<< (bus_pkg::NSEL_W * i_req.addr.split.lane);
	end

	//////////////////////////////
	// Stage register
	//////////////////////////////

	always_ff @(posedge i_clk)
	begin
		if (i_rst || !i_cyc || i_wide_err)
		begin
			r_cyc <= 1'b0;
			r_stb <= 1'b0;
		end
		else if (accept)
		begin
			r_cyc <= 1'b1;
			r_stb <= 1'b1;
		end
		else if (o_tag_push)
			r_stb <= 1'b0;
	end

	always_ff @(posedge i_clk)
	begin
		if (i_rst || !i_cyc)
			r_abort <= 1'b0;
		else if (i_wide_err)
			r_abort <= 1'b1;
	end

	// Payload, loaded on acceptance only
	always_ff @(posedge i_clk)
	begin
		if (accept)
		begin
			r_req.we <= i_req.we;
			r_req.row <= i_req.addr.split.row;
			r_req.data <= lane_data;
			r_req.sel <= lane_sel;
			r_lane <= i_req.addr.split.lane;
		end
	end

endmodule

// ==== src/upsz_rsp_stage.sv ====
//////////////////////////////
// Wide to narrow response stage
// Lane select, ack/err register
//////////////////////////////
`timescale 1ns/100ps
module upsz_rsp_stage (
	input  logic                 i_clk,
	input  logic                 i_rst,
	input  logic                 i_cyc,
	input  bus_pkg::wide_rsp_t   i_wide_rsp,
	input  bus_pkg::lane_t       i_tag,
	output logic                 o_tag_pop,
	output bus_pkg::narrow_rsp_t o_rsp
);

	// Registered narrow response
	logic r_ack;
	logic r_err;
	bus_pkg::narrow_data_t r_data;
	// Returned lane picked from the wide row
	bus_pkg::narrow_data_t lane_data;

	//////////////////////////////
	// Lane select
	//////////////////////////////

	// One tag per wide response, ack or err alike
	assign o_tag_pop = i_wide_rsp.ack || i_wide_rsp.err;

	// Tag names the lane, lane 0 in the low bits
	always_comb
	begin
		lane_data = i_wide_rsp.data[bus_pkg::NARROW_DW * i_tag +: bus_pkg::NARROW_DW];
	end

	//////////////////////////////
	// Output register
	//////////////////////////////

	// Dropped cyc kills any response in flight
	always_ff @(posedge i_clk)
	begin
		if (i_rst)
		begin
			r_ack <= 1'b0;
			r_err <= 1'b0;
		end
		else
		begin
			r_ack <= i_cyc && i_wide_rsp.ack;
			r_err <= i_cyc && i_wide_rsp.err;
		end
	end

	// Data follows the wide response, no reset
	always_ff @(posedge i_clk)
	begin
		if (o_tag_pop)
			r_data <= lane_data;
	end

	always_comb
	begin
		o_rsp.ack = r_ack;
		o_rsp.err = r_err;
		o_rsp.data = r_data;
	end

endmodule

// ==== src/upsz_top.sv ====
//////////////////////////////
// Upsizing bridge with memory
// Request, memory, response
//////////////////////////////
`timescale 1ns/100ps
module upsz_top (
	input  logic                 i_clk,
	input  logic                 i_rst,
	input  logic                 i_cyc,
	input  logic                 i_stb,
	input  bus_pkg::narrow_req_t i_req,
	output logic                 o_stall,
	output bus_pkg::narrow_rsp_t o_rsp
);

	// Wide bus between the stages and the memory
	logic wide_cyc;
	logic wide_stb;
	bus_pkg::wide_req_t wide_req;
	bus_pkg::wide_rsp_t wide_rsp;
	// Lane-tag queue signals
	logic tag_push;
	logic tag_pop;
	logic tag_full;
	bus_pkg::lane_t tag_in;
	bus_pkg::lane_t tag_out;

	//////////////////////////////
	// Pipeline
	//////////////////////////////

	upsz_req_stage u_req (
		.i_clk      (i_clk),
		.i_rst      (i_rst),
		.i_cyc      (i_cyc),
		.i_stb      (i_stb),
		.i_req      (i_req),
		.i_tag_full (tag_full),
		.i_wide_err (wide_rsp.err),
		.o_stall    (o_stall),
		.o_wide_cyc (wide_cyc),
		.o_wide_stb (wide_stb),
		.o_wide_req (wide_req),
		.o_tag_push (tag_push),
		.o_tag      (tag_in)
	);

	// Flushed whenever the master drops the cycle
	lane_tag_fifo u_tags (
		.i_clk   (i_clk),
		.i_rst   (i_rst),
		.i_flush (~i_cyc),
		.i_push  (tag_push),
		.i_tag   (tag_in),
		.i_pop   (tag_pop),
		.o_tag   (tag_out),
		.o_full  (tag_full)
	);

	wide_ram u_ram (
		.i_clk (i_clk),
		.i_rst (i_rst),
		.i_cyc (wide_cyc),
		.i_stb (wide_stb),
		.i_req (wide_req),
		.o_rsp (wide_rsp)
	);

	upsz_rsp_stage u_rsp (
		.i_clk      (i_clk),
		.i_rst      (i_rst),
		.i_cyc      (i_cyc),
		.i_wide_rsp (wide_rsp),
		.i_tag      (tag_out),
		.o_tag_pop  (tag_pop),
		.o_rsp      (o_rsp)
	);

endmodule

// ==== src/wide_ram.sv ====
//////////////////////////////
// Wide pipelined memory slave
// Byte writes, fixed read latency
// Err beyond implemented rows
//////////////////////////////
`timescale 1ns/100ps
module wide_ram (
	input  logic               i_clk,
	input  logic               i_rst,
	input  logic               i_cyc,
	input  logic               i_stb,
	input  bus_pkg::wide_req_t i_req,
	output bus_pkg::wide_rsp_t o_rsp
);

	// Storage, no reset
	bus_pkg::wide_data_t mem_array [mem_pkg::MEM_ROWS];
	// Response pipeline, index 0 loads at acceptance
	logic [mem_pkg::RD_LAT-1:0] pipe_vld;
	logic [mem_pkg::RD_LAT-1:0] pipe_err;
	bus_pkg::wide_data_t pipe_dat [mem_pkg::RD_LAT];
	// Request decode
	logic accept;
	logic in_range;
	logic [mem_pkg::MEM_AW-1:0] addr;

	// Never stalls, every strobe in a cycle is taken
	assign accept = i_cyc && i_stb;
	assign in_range = (i_req.row < bus_pkg::ROW_W'(mem_pkg::MEM_ROWS));
	assign addr = i_req.row[mem_pkg::MEM_AW-1:0];

	//////////////////////////////
	// Array write and read
	//////////////////////////////

	// Writes land at acceptance, out-of-range rows ignored
	always_ff @(posedge i_clk)
	begin
		if (accept && i_req.we && in_range)
		begin
			for (int b = 0; b < bus_pkg::WSEL_W; b++)
				if (i_req.sel[b])
					mem_array[addr][8*b +: 8] <= i_req.data[8*b +: 8];
		end
	end

	// Read data travels with the valid bits
	always_ff @(posedge i_clk)
	begin
		if (accept)
			pipe_dat[0] <= mem_array[addr];
		for (int k = mem_pkg::RD_LAT - 1; k > 0; k--)
			pipe_dat[k] <= pipe_dat[k-1];
	end

	// Valid and err shift, cleared by reset or end of cycle
	always_ff @(posedge i_clk)
	begin
		if (i_rst || !i_cyc)
		begin
			pipe_vld <= '0;
			pipe_err <= '0;
		end
		else
		begin
			pipe_vld[0] <= accept;
			pipe_err[0] <= accept && !in_range;
			for (int k = mem_pkg::RD_LAT - 1; k > 0; k--)
			begin
				pipe_vld[k] <= pipe_vld[k-1];
				pipe_err[k] <= pipe_err[k-1];
			end
		end
	end

	// Last stage drives the response while the cycle lasts
	always_comb
	begin
		o_rsp.ack = i_cyc && pipe_vld[mem_pkg::RD_LAT-1] && !pipe_err[mem_pkg::RD_LAT-1];
		o_rsp.err = i_cyc && pipe_vld[mem_pkg::RD_LAT-1] && pipe_err[mem_pkg::RD_LAT-1];
		o_rsp.data = pipe_dat[mem_pkg::RD_LAT-1];
	end

endmodule
